// ==== source/ptg_config.svh ====
// Table dimensions and field widths for the page table group lookup, included by packages and RTL
`ifndef PTG_CONFIG_SVH
`define PTG_CONFIG_SVH

// ============================================================
// Table geometry
// ============================================================

// Entries searched together in one group
`define PTE_PER_PTG 8
// Groups held in the on-chip table
`define PTG_COUNT 64
// Width of the group index taken from the top of the address
`define PTG_INDEX_W 6

// ============================================================
// Entry field widths
// ============================================================

`define ASID_W 12
`define PPN_W 16
`define VPN_W 16

`endif

// ==== source/mmu_pkg.sv ====
// Page table entry formats shared by the table, the search and the result stage
`include "ptg_config.svh"

package mmu_pkg;

	// Plain 32-bit virtual address as it arrives with a miss
	typedef logic [31:0] virtual_address_t;

	// Slot number inside a group
	typedef logic [$clog2(`PTE_PER_PTG)-1:0] entry_num_t;

	// ============================================================
	// Page table entry
	// ============================================================

	// Field view of one entry, most significant bit first
	typedef struct packed {
		logic v;
		logic g;
		logic s;
		logic [12:0] rsvd_hi;
		logic [`ASID_W-1:0] asid;
		logic [`VPN_W-1:0] vpn;
		logic [`PPN_W-1:0] ppn;
		logic [3:0] rsvd_lo;
	} pte_fields_t;

	// The write port sees the raw word, the search sees the fields
	typedef union packed {
		logic [63:0] raw;
		pte_fields_t f;
	} pte_word_u;

	// A whole group, slot 0 in the lowest 64 bits
	typedef pte_word_u [`PTE_PER_PTG-1:0] ptg_t;

endpackage

// ==== source/walk_pkg.sv ====
// Transaction structs passed between the stages of the lookup pipeline
`include "ptg_config.svh"

package walk_pkg;
	import mmu_pkg::*;

	// Miss request as presented at the input of the lookup
	typedef struct packed {
		logic [`ASID_W-1:0] asid;
		virtual_address_t miss_adr;
	} miss_req_t;

	// Outcome of searching one group, before the address is formed
	typedef struct packed {
		logic found;
		entry_num_t entry_num;
		pte_fields_t pte;
		virtual_address_t miss_adr;
	} search_res_t;

	// Final translation result handed to the consumer with done
	typedef struct packed {
		logic fault;
		entry_num_t entry_num;
		logic [31:0] paddr;
	} walk_res_t;

endpackage

// ==== source/miss_capture.sv ====
// Input stage of the lookup; registers a miss and delays it to line up with the table read
`timescale 1ns/100ps
`include "ptg_config.svh"

module miss_capture import walk_pkg::*; (
	input logic clk,
	input logic reset,
	input logic miss_valid,
	input miss_req_t miss_req,
	output logic [`PTG_INDEX_W-1:0] cap_index,
	output logic stage_valid,
	output miss_req_t stage_req
);

	logic cap_valid;
	miss_req_t cap_req;

	// ============================================================
	// First stage: capture and derive the group index
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= miss_valid;
		end
	end

	// The index comes straight from the incoming address so the table
	// can be addressed in the very next cycle
	always_ff @(posedge clk) begin
		cap_req <= miss_req;
		cap_index <= miss_req.miss_adr[31:26];
	end

	// ============================================================
	// Second stage: wait for the group read
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= cap_valid;
		end
	end

	// Request travels alongside rd_ptg from the table
	always_ff @(posedge clk) begin
		stage_req <= cap_req;
	end

	// A strobed miss must carry a known asid and address, or the group read goes astray
	a_req_known: assert property (@(posedge clk) disable iff (reset)
		miss_valid |-> !$isunknown(miss_req));

endmodule

// ==== source/ptg_table.sv ====
// On-chip page table storage; one entry written per strobe, one whole group read per cycle
`timescale 1ns/100ps
`include "ptg_config.svh"

module ptg_table import mmu_pkg::*; (
	input logic clk,
	input logic pte_wr,
	input logic [`PTG_INDEX_W-1:0] pte_group,
	input entry_num_t pte_slot,
	input pte_word_u pte_word,
	input logic [`PTG_INDEX_W-1:0] rd_index,
	output ptg_t rd_ptg
);

	// One row per group, each row the full set of entries
	ptg_t mem [`PTG_COUNT];

	// ============================================================
	// Write port
	// ============================================================

	// Only the addressed slot changes, the other entries of the row
	// keep their contents
	always_ff @(posedge clk) begin
		if (pte_wr) begin
			mem[pte_group][pte_slot].raw <= pte_word.raw;
		end
	end

	// ============================================================
	// Read port
	// ============================================================

	// Registered read of a whole group
	// A write in the same cycle lands after this read, so the new entry
	// shows up for an index registered on the following edge
	always_ff @(posedge clk) begin
		rd_ptg <= mem[rd_index];
	end

	// An unknown strobe would corrupt an unknown slot
	a_wr_known: assert property (@(posedge clk) !$isunknown(pte_wr));

endmodule

// ==== source/ptg_search.sv ====
// Combinational search of one page table group for the first matching entry
`timescale 1ns/100ps
`include "ptg_config.svh"

module ptg_search import mmu_pkg::*, walk_pkg::*; (
	input ptg_t ptg,
	input logic [`ASID_W-1:0] asid,
	input virtual_address_t miss_adr,
	output search_res_t res
);

	// Per-slot hit flags, computed in parallel
	logic [`PTE_PER_PTG-1:0] hit;

	// ============================================================
	// Match rule per slot
	// ============================================================

	// The top vpn bits must equal the group part of the address
	// Superpages ignore the lower vpn bits, global entries ignore the asid
	always_comb begin
		for (int k = 0; k < `PTE_PER_PTG; k++) begin
			hit[k] = ptg[k].f.v
				&& ptg[k].f.vpn[15:10] == miss_adr[31:26]
				&& (ptg[k].f.s || ptg[k].f.vpn[9:0] == miss_adr[25:16])
				&& (ptg[k].f.g || ptg[k].f.asid == asid);
		end
	end

	// ============================================================
	// Priority pick, lowest slot first
	// ============================================================

	// Walk down from the top so that the lowest hitting slot is the last
	// one written and wins
	always_comb begin
		res.found = 1'b0;
		res.entry_num = '0;
		res.pte = '0;
		res.miss_adr = miss_adr;
		for (int k = `PTE_PER_PTG - 1; k >= 0; k--) begin
			if (hit[k]) begin
				res.found = 1'b1;
				res.entry_num = entry_num_t'(k);
				res.pte = ptg[k].f;
			end
		end
	end

endmodule

// ==== source/walk_result.sv ====
// Output stage of the lookup; registers the search outcome as a physical address or a fault
`timescale 1ns/100ps

module walk_result import walk_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input search_res_t search,
	output logic done,
	output walk_res_t result
);

	walk_res_t result_next;

	// ============================================================
	// Address formation
	// ============================================================

	// Pages are 64 KB, so a normal page keeps sixteen offset bits
	// A superpage keeps only the top six ppn bits and passes the rest
	// of the address through
	always_comb begin
		result_next.fault = !search.found;
		result_next.entry_num = search.entry_num;
		if (!search.found) begin
			result_next.paddr = '0;
		end else if (search.pte.s) begin
			result_next.paddr = {search.pte.ppn[15:10], search.miss_adr[25:0]};
		end else begin
			result_next.paddr = {search.pte.ppn, search.miss_adr[15:0]};
		end
	end

	// ============================================================
	// Output registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= in_valid;
		end
	end

	// Result is only meaningful with done
	always_ff @(posedge clk) begin
		result <= result_next;
	end

endmodule

// ==== source/ptw_top.sv ====
// Top level of the page table group lookup; ties capture, table, search and result together
`timescale 1ns/100ps
`include "ptg_config.svh"

module ptw_top import mmu_pkg::*, walk_pkg::*; (
	input logic clk,
	input logic reset,
	input logic miss_valid,
	input miss_req_t miss_req,
	input logic pte_wr,
	input logic [`PTG_INDEX_W-1:0] pte_group,
	input entry_num_t pte_slot,
	input pte_word_u pte_word,
	output logic done,
	output walk_res_t result
);

	logic [`PTG_INDEX_W-1:0] cap_index;
	logic stage_valid;
	miss_req_t stage_req;
	ptg_t rd_ptg;
	search_res_t search_res;

	// ============================================================
	// Pipeline: capture, group read, search, result
	// ============================================================

	miss_capture i_miss_capture (
		.clk(clk),
		.reset(reset),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.cap_index(cap_index),
		.stage_valid(stage_valid),
		.stage_req(stage_req)
	);

	// Group read lines up with the second capture stage
	ptg_table i_ptg_table (
		.clk(clk),
		.pte_wr(pte_wr),
		.pte_group(pte_group),
		.pte_slot(pte_slot),
		.pte_word(pte_word),
		.rd_index(cap_index),
		.rd_ptg(rd_ptg)
	);

	ptg_search i_ptg_search (
		.ptg(rd_ptg),
		.asid(stage_req.asid),
		.miss_adr(stage_req.miss_adr),
		.res(search_res)
	);

	walk_result i_walk_result (
		.clk(clk),
		.reset(reset),
		.in_valid(stage_valid),
		.search(search_res),
		.done(done),
		.result(result)
	);

endmodule

// ==== dv/tb_ptw.sv ====
// Testbench for the page table group lookup; replays table writes and lookups from the pattern file
`timescale 1ns/100ps
`include "ptg_config.svh"

module tb_ptw import mmu_pkg::*, walk_pkg::*; ();

	logic clk;
	logic reset;
	logic miss_valid;
	miss_req_t miss_req;
	logic pte_wr;
	logic [`PTG_INDEX_W-1:0] pte_group;
	entry_num_t pte_slot;
	pte_word_u pte_word;
	logic done;
	walk_res_t result;

	// Outstanding lookups in request order, with the cycle each one was driven
	walk_res_t exp_q[$];
	int issue_q[$];
	int id_q[$];
	int cycle = 0;
	walk_res_t exp_res;
	int exp_cycle;
	int exp_id;

	ptw_top i_ptw_top (
		.clk(clk),
		.reset(reset),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.pte_wr(pte_wr),
		.pte_group(pte_group),
		.pte_slot(pte_slot),
		.pte_word(pte_word),
		.done(done),
		.result(result)
	);

	// ============================================================
	// Clock and cycle count
	// ============================================================

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
				$time, name, got, exp));
		end
	endtask

	// ============================================================
	// Result monitor, sampled on the falling edge
	// ============================================================

	// A miss driven after edge M is sampled at M+1 and completes at M+3
	always @(negedge clk) begin
		if (reset) begin
			check_value("done", 32'(done), 32'd0);
		end else if (done) begin
			if (exp_q.size() == 0) begin
				report_failure("A result came out while no lookup was outstanding");
			end else begin
				exp_res = exp_q.pop_front();
				exp_cycle = issue_q.pop_front();
				exp_id = id_q.pop_front();
				check_value($sformatf("done cycle of lookup %0d", exp_id), cycle, exp_cycle + 3);
				check_value($sformatf("result.fault of lookup %0d", exp_id),
					32'(result.fault), 32'(exp_res.fault));
				check_value($sformatf("result.entry_num of lookup %0d", exp_id),
					32'(result.entry_num), 32'(exp_res.entry_num));
				check_value($sformatf("result.paddr of lookup %0d", exp_id),
					result.paddr, exp_res.paddr);
			end
		end
	end

	// ============================================================
	// Stimulus from the pattern file
	// ============================================================

	initial begin : stimulus
		int fd;
		int code;
		int ch;
		int lookups;
		int wait_cycles;
		bit file_end;
		logic [7:0] cmd;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] arg_c;
		logic [31:0] arg_d;
		logic [31:0] arg_e;
		logic [63:0] arg_word;
		walk_res_t next_exp;

		clk = 1'b0;
		reset = 1'b1;
		miss_valid = 1'b0;
		miss_req = '0;
		pte_wr = 1'b0;
		pte_group = '0;
		pte_slot = '0;
		pte_word = '0;
		lookups = 0;
		file_end = 1'b0;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;

		fd = $fopen("dv/ptw_patterns.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the pattern file dv/ptw_patterns.txt");
		end
		while (!file_end) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				file_end = 1'b1;
			end else if (cmd == "#") begin
				// Comment line, skip up to the newline
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (cmd == "W") begin
				code = $fscanf(fd, "%d %d %h", arg_a, arg_b, arg_word);
				if (code != 3) begin
					report_failure("Malformed table write line in the pattern file");
				end
				@(posedge clk);
				#1;
				miss_valid = 1'b0;
				pte_wr = 1'b1;
				pte_group = arg_a[`PTG_INDEX_W-1:0];
				pte_slot = arg_b[2:0];
				pte_word.raw = arg_word;
			end else if (cmd == "L") begin
				code = $fscanf(fd, "%h %h %d %d %h", arg_a, arg_b, arg_c, arg_d, arg_e);
				if (code != 5) begin
					report_failure("Malformed lookup line in the pattern file");
				end
				next_exp.fault = arg_c[0];
				next_exp.entry_num = arg_d[2:0];
				next_exp.paddr = arg_e;
				@(posedge clk);
				#1;
				pte_wr = 1'b0;
				miss_valid = 1'b1;
				miss_req.asid = arg_a[`ASID_W-1:0];
				miss_req.miss_adr = arg_b;
				exp_q.push_back(next_exp);
				issue_q.push_back(cycle);
				id_q.push_back(lookups);
				lookups++;
			end else begin
				report_failure("Unknown command letter in the pattern file");
			end
		end
		$fclose(fd);
		@(posedge clk);
		#1;
		miss_valid = 1'b0;
		pte_wr = 1'b0;

		// Let the pipe drain, bounded in case a result never shows up
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < 100) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_q.size() != 0) begin
			report_failure($sformatf("Lookup %0d got no result within 100 cycles", id_q[0]));
		end else begin
			// A few idle cycles to catch a stray done
			repeat (5) @(posedge clk);
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+source
source/mmu_pkg.sv
source/walk_pkg.sv
source/miss_capture.sv
source/ptg_table.sv
source/ptg_search.sv
source/walk_result.sv
source/ptw_top.sv
dv/tb_ptw.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the page table group lookup testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_ptw -f filelist.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_ptw 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "Simulation completed successfully"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== dv/ptw_patterns.txt ====
# W group slot word : group and slot in decimal, raw 64-bit entry word in hex
# L asid address fault entry paddr : asid, address and paddr in hex, fault and entry in decimal
W 5 0 00001231404AAAA0
W 5 1 80001231401BEEF0
W 5 2 8000456140211110
W 5 3 C000000140322220
W 5 4 8000123140233330
W 5 5 A0000AB140054000
W 5 6 0000000000000000
W 5 7 0000000000000000
W 9 0 8000321240177770
W 9 1 0000000000000000
W 9 2 0000000000000000
W 9 3 8000321240530030
W 9 4 0000000000000000
W 9 5 0000000000000000
W 9 6 8000321240560060
W 9 7 0000000000000000
L 123 14011234 0 1 BEEF1234
L 123 14025678 0 4 33335678
L 456 14025678 0 2 11115678
L 777 14039ABC 0 3 22229ABC
L 0AB 16ABCDEF 0 5 56ABCDEF
L 123 14040000 1 0 00000000
L 321 24020000 1 0 00000000
L 321 240500FF 0 3 300300FF
L 5A5 14039ABC 0 3 22229ABC
